/* sim.f */
+incdir+include
hdl/div_pkg.sv
hdl/div_norm_if.sv
hdl/div_rem_if.sv
hdl/div_fsm.sv
hdl/div_prenorm.sv
hdl/div_qds_table.sv
hdl/div_srt_iter.sv
hdl/div_postproc.sv
hdl/srt_div.sv
test/div_checker.sv
test/tb_srt_div.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_srt_div
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* test/tb_srt_div.sv */
/*
 * testbench for the radix-4 srt divider
 * clock, reset, stimulus, reference model and timeout
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module tb_srt_div;

	localparam int N_UNS     = 40;
	localparam int N_SGN     = 43;
	localparam int N_ZERO    = 6;
	localparam int N_BP      = 20;
	localparam int N_FLUSH   = 6;
	localparam int N_FLUSHED = 3;
	localparam int N_OPS     = N_UNS + N_SGN + N_ZERO + N_BP + N_FLUSH;
	// worst case about 21 cycles per op, rest is back-pressure slack
	localparam int TIMEOUT_CYCLES = N_OPS * 40 + 200;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  flush;
	logic                  start_valid;
	logic                  start_ready;
	logic                  signed_op;
	logic [`DIV_WIDTH-1:0] dividend;
	logic [`DIV_WIDTH-1:0] divisor;
	logic                  finish_valid;
	logic                  finish_ready;
	logic [`DIV_WIDTH-1:0] quotient;
	logic [`DIV_WIDTH-1:0] remainder;
	logic                  div_zero;
	logic                  exp_zero;
	logic [`DIV_WIDTH-1:0] exp_quot;
	logic [`DIV_WIDTH-1:0] exp_rem;
	int                    err_cnt;
	int                    chk_cnt;
	int                    tb_err    = 0;
	int                    cycle_cnt = 0;
	integer                seed      = 32'hc29b027e;

	always #5 clk = ~clk;

	srt_div srt_div_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush_i        (flush),
		.start_valid_i  (start_valid),
		.start_ready_o  (start_ready),
		.signed_i       (signed_op),
		.dividend_i     (dividend),
		.divisor_i      (divisor),
		.finish_valid_o (finish_valid),
		.finish_ready_i (finish_ready),
		.quotient_o     (quotient),
		.remainder_o    (remainder),
		.div_zero_o     (div_zero)
	);

	div_checker checker_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush_i        (flush),
		.start_valid_i  (start_valid),
		.start_ready_i  (start_ready),
		.signed_i       (signed_op),
		.dividend_i     (dividend),
		.divisor_i      (divisor),
		.exp_zero_i     (exp_zero),
		.exp_quot_i     (exp_quot),
		.exp_rem_i      (exp_rem),
		.finish_valid_i (finish_valid),
		.finish_ready_i (finish_ready),
		.quotient_i     (quotient),
		.remainder_i    (remainder),
		.div_zero_i     (div_zero),
		.err_cnt_o      (err_cnt),
		.chk_cnt_o      (chk_cnt)
	);

	// ========================================================================
	// reference model, returns {div_zero, quotient, remainder}
	// ========================================================================
	function automatic logic [2*`DIV_WIDTH:0] ref_div(input logic sgn,
		input logic [`DIV_WIDTH-1:0] a, input logic [`DIV_WIDTH-1:0] b);
		logic [`DIV_WIDTH-1:0] ua;
		logic [`DIV_WIDTH-1:0] ub;
		logic [`DIV_WIDTH-1:0] q;
		logic [`DIV_WIDTH-1:0] r;
		logic                  na;
		logic                  nb;
		// divide by zero: all ones, dividend comes back
		if (b == '0)
			return {1'b1, {`DIV_WIDTH{1'b1}}, a};
		// most negative over minus one gives the dividend back
		if (sgn && a == {1'b1, {(`DIV_WIDTH-1){1'b0}}} && b == '1)
			return {1'b0, a, {`DIV_WIDTH{1'b0}}};
		na = sgn & a[`DIV_WIDTH-1];
		nb = sgn & b[`DIV_WIDTH-1];
		ua = na ? -a : a;
		ub = nb ? -b : b;
		// truncating division, remainder follows the dividend sign
		q  = ua / ub;
		r  = ua % ub;
		if (na ^ nb)
			q = -q;
		if (na)
			r = -r;
		return {1'b0, q, r};
	endfunction

	function automatic int total_errors();
		return err_cnt + tb_err;
	endfunction

	// ========================================================================
	// stimulus tasks, all start and end 1 ns after a rising edge
	// ========================================================================
	task automatic pick_operands(input int mode, output logic [`DIV_WIDTH-1:0] a,
		output logic [`DIV_WIDTH-1:0] b);
		logic [`DIV_WIDTH-1:0] r;
		a = $random(seed);
		b = $random(seed);
		r = $random(seed);
		case (mode)
			// dividend below the divisor
			1: a = b >> (1 + r[2:0]);
			// short divisor, long iteration
			2: b = b >> r[4:0];
			3: b = b & 32'h0000_00ff;
			default: ;
		endcase
	endtask

	task automatic drive_start(input logic sgn, input logic [`DIV_WIDTH-1:0] a,
		input logic [`DIV_WIDTH-1:0] b);
		logic [2*`DIV_WIDTH:0] exp_res;
		exp_res     = ref_div(sgn, a, b);
		signed_op   = sgn;
		dividend    = a;
		divisor     = b;
		exp_zero    = exp_res[2*`DIV_WIDTH];
		exp_quot    = exp_res[2*`DIV_WIDTH-1:`DIV_WIDTH];
		exp_rem     = exp_res[`DIV_WIDTH-1:0];
		start_valid = 1'b1;
	endtask

	task automatic wait_accept();
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = start_ready;
		end
		#1;
		start_valid = 1'b0;
	endtask

	// random ready stretches when back-pressure is on
	task automatic wait_finish(input bit bp);
		bit taken;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = finish_valid && finish_ready;
			#1;
			if (bp)
				finish_ready = (($random(seed) & 3) == 0);
		end
	endtask

	task automatic run_op(input logic sgn, input logic [`DIV_WIDTH-1:0] a,
		input logic [`DIV_WIDTH-1:0] b, input bit bp);
		drive_start(sgn, a, b);
		wait_accept();
		wait_finish(bp);
	endtask

	task automatic report_test(input int num, input string name, input int ops,
		input int err_start);
		$display("test %0d %s: %0d ops, %0d errors", num, name, ops,
			total_errors() - err_start);
	endtask

	// ========================================================================
	// timeout
	// ========================================================================
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		logic [`DIV_WIDTH-1:0] a;
		logic [`DIV_WIDTH-1:0] b;
		int                    err_start;
		int                    combo;
		int                    flush_at[3];

		rst_n        = 1'b0;
		flush        = 1'b0;
		start_valid  = 1'b0;
		signed_op    = 1'b0;
		dividend     = '0;
		divisor      = '0;
		finish_ready = 1'b1;
		exp_zero     = 1'b0;
		exp_quot     = '0;
		exp_rem      = '0;
		flush_at     = '{0, 3, 9};
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// unsigned random, a quarter with the dividend below the divisor
		err_start = total_errors();
		for (int i = 0; i < N_UNS; i++) begin
			pick_operands(i % 4, a, b);
			run_op(1'b0, a, b, 1'b0);
		end
		report_test(1, "unsigned random", N_UNS, err_start);

		// signed, every sign combination, then the overflow corners
		err_start = total_errors();
		for (int i = 0; i < N_SGN - 3; i++) begin
			pick_operands(i % 4, a, b);
			combo = (i / 4) % 4;
			a[`DIV_WIDTH-1] = 1'b0;
			b[`DIV_WIDTH-1] = 1'b0;
			if (combo[0])
				a = -a;
			if (combo[1])
				b = -b;
			run_op(1'b1, a, b, 1'b0);
		end
		run_op(1'b1, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_op(1'b1, 32'h8000_0000, 32'h0000_0001, 1'b0);
		run_op(1'b1, 32'h7fff_ffff, 32'hffff_ffff, 1'b0);
		report_test(2, "signed random", N_SGN, err_start);

		// divide by zero, unsigned then signed
		err_start = total_errors();
		for (int i = 0; i < N_ZERO; i++) begin
			case (i % 3)
				0: a = '0;
				1: a = 32'h8000_0000;
				default: a = $random(seed);
			endcase
			run_op(i >= 3, a, '0, 1'b0);
		end
		report_test(3, "divide by zero", N_ZERO, err_start);

		// back-pressure on the finish side
		err_start = total_errors();
		for (int i = 0; i < N_BP; i++) begin
			pick_operands(i % 4, a, b);
			run_op(i % 2, a, b, 1'b1);
		end
		finish_ready = 1'b1;
		report_test(4, "back-pressure", N_BP, err_start);

		// flush a long operation at PRE, LOAD+1 and mid ITER
		err_start = total_errors();
		for (int i = 0; i < N_FLUSHED; i++) begin
			drive_start(1'b0, 32'hffff_fff0, 32'h0000_0003);
			wait_accept();
			repeat (flush_at[i]) @(posedge clk);
			#1;
			flush = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
			if (!start_ready) begin
				$display("start_ready_o stayed low after flush %0d", i);
				tb_err++;
			end
			// the flushed operation must stay silent
			repeat (25) begin
				@(posedge clk);
				#1;
				if (finish_valid) begin
					$display("finish_valid_o rose for flushed operation %0d", i);
					tb_err++;
				end
			end
			pick_operands(i + 1, a, b);
			run_op(1'b1, a, b, 1'b0);
		end
		report_test(5, "flush", N_FLUSH, err_start);

		// every accepted, unflushed operation returns exactly once
		if (chk_cnt != N_OPS - N_FLUSHED) begin
			$display("expected %0d results but %0d arrived", N_OPS - N_FLUSHED, chk_cnt);
			tb_err++;
		end
		$display("summary: %0d results checked, %0d errors", chk_cnt, total_errors());
		if (total_errors() == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* test/div_checker.sv */
/*
 * result checker for the srt divider
 * queues expected results on start, compares on finish, watches held results
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush_i,
	input  logic                  start_valid_i,
	input  logic                  start_ready_i,
	input  logic                  signed_i,
	input  logic [`DIV_WIDTH-1:0] dividend_i,
	input  logic [`DIV_WIDTH-1:0] divisor_i,
	input  logic                  exp_zero_i,
	input  logic [`DIV_WIDTH-1:0] exp_quot_i,
	input  logic [`DIV_WIDTH-1:0] exp_rem_i,
	input  logic                  finish_valid_i,
	input  logic                  finish_ready_i,
	input  logic [`DIV_WIDTH-1:0] quotient_i,
	input  logic [`DIV_WIDTH-1:0] remainder_i,
	input  logic                  div_zero_i,
	output int                    err_cnt_o,
	output int                    chk_cnt_o
);

	// one accepted operation and its expected result
	typedef struct packed {
		logic                  sgn;
		logic [`DIV_WIDTH-1:0] dvd;
		logic [`DIV_WIDTH-1:0] dvs;
		logic                  zero;
		logic [`DIV_WIDTH-1:0] quot;
		logic [`DIV_WIDTH-1:0] rem;
	} op_t;

	op_t                   exp_q[$];
	op_t                   ctx;
	logic                  stall_q;
	logic [`DIV_WIDTH-1:0] held_quot;
	logic [`DIV_WIDTH-1:0] held_rem;
	logic                  held_zero;

	task automatic check_value(input string name, input logic [`DIV_WIDTH-1:0] exp_val,
		input logic [`DIV_WIDTH-1:0] act_val);
		if (exp_val !== act_val) begin
			$display("Fail %s: expected %h, got %h (dividend %h, divisor %h, signed %0d)",
				name, exp_val, act_val, ctx.dvd, ctx.dvs, ctx.sgn);
			err_cnt_o++;
		end
	endtask

	// ========================================================================
	// sampled on the clock edge, DUT outputs are registered
	// ========================================================================
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_q.delete();
			stall_q   = 1'b0;
			err_cnt_o = 0;
			chk_cnt_o = 0;
		end else begin
			// a waiting result must not move
			if (stall_q) begin
				if (exp_q.size() > 0)
					ctx = exp_q[0];
				if (!finish_valid_i) begin
					$display("finish_valid_o dropped while a result was still waiting");
					err_cnt_o++;
				end else begin
					check_value("quotient_o held", held_quot, quotient_i);
					check_value("remainder_o held", held_rem, remainder_i);
					check_value("div_zero_o held", {{(`DIV_WIDTH-1){1'b0}}, held_zero},
						{{(`DIV_WIDTH-1){1'b0}}, div_zero_i});
				end
			end

			// result taken, compare against the oldest pending operation
			if (finish_valid_i && finish_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("a result was delivered with no operation pending");
					err_cnt_o++;
				end else begin
					ctx = exp_q.pop_front();
					check_value("quotient_o", ctx.quot, quotient_i);
					check_value("remainder_o", ctx.rem, remainder_i);
					check_value("div_zero_o", {{(`DIV_WIDTH-1){1'b0}}, ctx.zero},
						{{(`DIV_WIDTH-1){1'b0}}, div_zero_i});
					chk_cnt_o++;
				end
			end

			stall_q   = finish_valid_i & ~finish_ready_i;
			held_quot = quotient_i;
			held_rem  = remainder_i;
			held_zero = div_zero_i;

			// flushed operation never finishes
			if (flush_i)
				exp_q.delete();
			else if (start_valid_i && start_ready_i)
				exp_q.push_back('{sgn: signed_i, dvd: dividend_i, dvs: divisor_i,
					zero: exp_zero_i, quot: exp_quot_i, rem: exp_rem_i});
		end
	end

endmodule

/* hdl/srt_div.sv */
/*
 * 32-bit radix-4 srt integer divider
 * signed or unsigned, one quotient digit per cycle
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module srt_div import div_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush_i,
	input  logic                  start_valid_i,
	output logic                  start_ready_o,
	input  logic                  signed_i,
	input  logic [`DIV_WIDTH-1:0] dividend_i,
	input  logic [`DIV_WIDTH-1:0] divisor_i,
	output logic                  finish_valid_o,
	input  logic                  finish_ready_i,
	output logic [`DIV_WIDTH-1:0] quotient_o,
	output logic [`DIV_WIDTH-1:0] remainder_o,
	output logic                  div_zero_o
);

	div_state_e  state;
	qds_thresh_t thresh;
	logic        start_fire;

	div_norm_if norm_if ();
	div_rem_if  rem_if ();

	assign start_fire = start_valid_i & start_ready_o;

	div_fsm fsm_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush_i        (flush_i),
		.start_valid_i  (start_valid_i),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o),
		.finish_ready_i (finish_ready_i),
		.state_o        (state),
		.norm           (norm_if)
	);

	div_prenorm prenorm_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.state_i      (state),
		.start_fire_i (start_fire),
		.signed_i     (signed_i),
		.dividend_i   (dividend_i),
		.divisor_i    (divisor_i),
		.norm         (norm_if)
	);

	// bits just below the leading one of the normalized divisor
	div_qds_table qds_table_i (
		.clk            (clk),
		.state_i        (state),
		.divisor_bits_i (norm_if.norm_divisor[`DIV_WIDTH-2 -: 3]),
		.thresh_o       (thresh)
	);

	div_srt_iter srt_iter_i (
		.clk      (clk),
		.state_i  (state),
		.thresh_i (thresh),
		.norm     (norm_if),
		.rem      (rem_if)
	);

	div_postproc postproc_i (
		.clk         (clk),
		.state_i     (state),
		.norm        (norm_if),
		.rem         (rem_if),
		.quotient_o  (quotient_o),
		.remainder_o (remainder_o),
		.div_zero_o  (div_zero_o)
	);

endmodule

/* hdl/div_postproc.sv */
/*
 * divider post stage
 * remainder resolve, correction, sign fix and denormalizing shift
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_postproc import div_pkg::*; (
	input  logic                  clk,
	input  div_state_e            state_i,
	div_norm_if.user              norm,
	div_rem_if.post               rem,
	output logic [`DIV_WIDTH-1:0] quotient_o,
	output logic [`DIV_WIDTH-1:0] remainder_o,
	output logic                  div_zero_o
);

	logic [`DIV_ITN_WIDTH-1:0] rem_nr;
	logic [`DIV_ITN_WIDTH-1:0] rem_fix;
	logic                      need_corr;
	logic [`DIV_WIDTH-1:0]     quot_sel;
	logic [`DIV_WIDTH-1:0]     rem_abs;

	// ========================================================================
	// resolve and correct
	// ========================================================================
	assign rem_nr    = rem.rem_sum + rem.rem_carry;
	// negative remainder means the quotient is one too large
	assign need_corr = rem_nr[`DIV_ITN_WIDTH-1];
	assign rem_fix   = need_corr ? rem_nr + {1'b0, norm.norm_divisor, 3'b000} : rem_nr;
	assign quot_sel  = need_corr ? rem.quot_m1 : rem.quot;

	// undo the divisor normalization
	assign rem_abs = rem_fix[`DIV_ITN_WIDTH-2:3] >> norm.rem_shift;

	// results hold through DONE
	always_ff @(posedge clk) begin
		if (state_i == POST) begin
			quotient_o  <= norm.quot_neg ? -quot_sel : quot_sel;
			remainder_o <= norm.rem_neg ? -rem_abs : rem_abs;
			div_zero_o  <= norm.div_zero;
		end
	end

endmodule

/* hdl/div_srt_iter.sv */
/*
 * radix-4 srt recurrence
 * carry-save remainder, digit selection and on-the-fly quotient
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_srt_iter import div_pkg::*; (
	input  logic        clk,
	input  div_state_e  state_i,
	input  qds_thresh_t thresh_i,
	div_norm_if.user    norm,
	div_rem_if.iter     rem
);

	logic signed [6:0]         est;
	quot_digit_e               digit;
	logic [`DIV_ITN_WIDTH-1:0] x1;
	logic [`DIV_ITN_WIDTH-1:0] x2;
	logic [`DIV_ITN_WIDTH-1:0] x3;
	logic [`DIV_ITN_WIDTH-1:0] d1;
	logic [`DIV_ITN_WIDTH-1:0] d2;
	logic [`DIV_ITN_WIDTH-1:0] maj;
	logic                      pos_digit;
	logic [`DIV_WIDTH-1:0]     quot_nxt;
	logic [`DIV_WIDTH-1:0]     quot_m1_nxt;

	// ========================================================================
	// digit selection
	// ========================================================================
	// top seven bits of sum and carry give 4w with four fraction bits
	assign est = signed'(rem.rem_sum[`DIV_ITN_WIDTH-1 -: 7]
		+ rem.rem_carry[`DIV_ITN_WIDTH-1 -: 7]);

	always_comb begin
		if (est >= thresh_i.m_p2)
			digit = Q_POS2;
		else if (est >= thresh_i.m_p1)
			digit = Q_POS1;
		else if (est >= thresh_i.m_z)
			digit = Q_ZERO;
		else if (est >= thresh_i.m_n1)
			digit = Q_NEG1;
		else
			digit = Q_NEG2;
	end

	// ========================================================================
	// 3:2 carry-save step, w' = 4w - q*d
	// ========================================================================
	// divisor sits below the sign bit with three fraction bits
	assign d1 = {1'b0, norm.norm_divisor, 3'b000};
	assign d2 = {norm.norm_divisor, 4'b0000};
	assign x1 = {rem.rem_sum[`DIV_ITN_WIDTH-3:0], 2'b00};
	assign x2 = {rem.rem_carry[`DIV_ITN_WIDTH-3:0], 2'b00};

	always_comb begin
		unique case (digit)
			Q_POS2:  x3 = ~d2;
			Q_POS1:  x3 = ~d1;
			Q_NEG1:  x3 = d1;
			Q_NEG2:  x3 = d2;
			default: x3 = '0;
		endcase
	end

	assign maj = (x1 & x2) | (x1 & x3) | (x2 & x3);
	// +1 of the two's complement goes into the free carry lsb
	assign pos_digit = (digit == Q_POS1) || (digit == Q_POS2);

	// ========================================================================
	// on-the-fly conversion
	// ========================================================================
	always_comb begin
		unique case (digit)
			Q_POS2: begin
				quot_nxt    = {rem.quot[`DIV_WIDTH-3:0], 2'b10};
				quot_m1_nxt = {rem.quot[`DIV_WIDTH-3:0], 2'b01};
			end
			Q_POS1: begin
				quot_nxt    = {rem.quot[`DIV_WIDTH-3:0], 2'b01};
				quot_m1_nxt = {rem.quot[`DIV_WIDTH-3:0], 2'b00};
			end
			Q_NEG1: begin
				quot_nxt    = {rem.quot_m1[`DIV_WIDTH-3:0], 2'b11};
				quot_m1_nxt = {rem.quot_m1[`DIV_WIDTH-3:0], 2'b10};
			end
			Q_NEG2: begin
				quot_nxt    = {rem.quot_m1[`DIV_WIDTH-3:0], 2'b10};
				quot_m1_nxt = {rem.quot_m1[`DIV_WIDTH-3:0], 2'b01};
			end
			default: begin
				quot_nxt    = {rem.quot[`DIV_WIDTH-3:0], 2'b00};
				quot_m1_nxt = {rem.quot_m1[`DIV_WIDTH-3:0], 2'b11};
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (state_i == LOAD) begin
			rem.rem_sum   <= norm.rem_init;
			rem.rem_carry <= '0;
			rem.quot      <= norm.quot_init;
			rem.quot_m1   <= norm.quot_init - `DIV_WIDTH'(1);
		end else if (state_i == ITER) begin
			rem.rem_sum   <= x1 ^ x2 ^ x3;
			rem.rem_carry <= {maj[`DIV_ITN_WIDTH-2:0], pos_digit};
			rem.quot      <= quot_nxt;
			rem.quot_m1   <= quot_m1_nxt;
		end
	end

endmodule

/* hdl/div_qds_table.sv */
/*
 * digit-selection constants
 * looked up from the three divisor bits below the leading one
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_qds_table import div_pkg::*; (
	input  logic        clk,
	input  div_state_e  state_i,
	input  logic [2:0]  divisor_bits_i,
	output qds_thresh_t thresh_o
);

	qds_thresh_t thresh_c;

	// ========================================================================
	// radix-4 table, digit set -2..2, 4w estimate with four fraction bits
	// ========================================================================
	// columns are m_z, m_p1, m_p2, m_n1
	always_comb begin
		unique case (divisor_bits_i)
			3'd0:    thresh_c = '{m_z: -6'sd4, m_p1: 6'sd4, m_p2: 6'sd12, m_n1: -6'sd13};
			3'd1:    thresh_c = '{m_z: -6'sd6, m_p1: 6'sd4, m_p2: 6'sd14, m_n1: -6'sd15};
			3'd2:    thresh_c = '{m_z: -6'sd6, m_p1: 6'sd4, m_p2: 6'sd15, m_n1: -6'sd16};
			3'd3:    thresh_c = '{m_z: -6'sd6, m_p1: 6'sd4, m_p2: 6'sd16, m_n1: -6'sd17};
			3'd4:    thresh_c = '{m_z: -6'sd6, m_p1: 6'sd6, m_p2: 6'sd18, m_n1: -6'sd19};
			3'd5:    thresh_c = '{m_z: -6'sd8, m_p1: 6'sd6, m_p2: 6'sd20, m_n1: -6'sd20};
			3'd6:    thresh_c = '{m_z: -6'sd8, m_p1: 6'sd6, m_p2: 6'sd22, m_n1: -6'sd22};
			default: thresh_c = '{m_z: -6'sd8, m_p1: 6'sd8, m_p2: 6'sd22, m_n1: -6'sd24};
		endcase
	end

	// held for the whole iteration phase
	always_ff @(posedge clk) begin
		if (state_i == LOAD)
			thresh_o <= thresh_c;
	end

endmodule

/* hdl/div_prenorm.sv */
/*
 * divider preprocessing
 * absolute values, leading-zero normalization, early exit and iteration count
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_prenorm import div_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  div_state_e            state_i,
	input  logic                  start_fire_i,
	input  logic                  signed_i,
	input  logic [`DIV_WIDTH-1:0] dividend_i,
	input  logic [`DIV_WIDTH-1:0] divisor_i,
	div_norm_if.prenorm           norm
);

	logic                      dvd_sign;
	logic                      dvs_sign;
	logic [`DIV_WIDTH-1:0]     dvd_abs_q;
	logic [`DIV_WIDTH-1:0]     dvs_abs_q;
	logic                      sign_xor_q;
	logic [`DIV_LZC_WIDTH:0]   lz_dvd;
	logic [`DIV_LZC_WIDTH:0]   lz_dvs;
	logic [`DIV_WIDTH-1:0]     norm_dvd;
	logic [`DIV_WIDTH-1:0]     norm_dvs;
	logic [`DIV_LZC_WIDTH-1:0] lz_diff;
	logic [`DIV_LZC_WIDTH:0]   iter_sum;
	logic                      too_small;
	logic                      skip_c;
	logic [`DIV_ITN_WIDTH-1:0] rem_init_c;

	// ========================================================================
	// absolute values, captured on the start edge
	// ========================================================================
	assign dvd_sign = signed_i & dividend_i[`DIV_WIDTH-1];
	assign dvs_sign = signed_i & divisor_i[`DIV_WIDTH-1];

	always_ff @(posedge clk) begin
		if (start_fire_i) begin
			dvd_abs_q <= dvd_sign ? -dividend_i : dividend_i;
			dvs_abs_q <= dvs_sign ? -divisor_i : divisor_i;
		end
	end

	// remainder takes the dividend sign
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sign_xor_q   <= 1'b0;
			norm.rem_neg <= 1'b0;
		end else if (start_fire_i) begin
			sign_xor_q   <= dvd_sign ^ dvs_sign;
			norm.rem_neg <= dvd_sign;
		end
	end

	// ========================================================================
	// normalize and set up the iteration, registered at the end of PRE
	// ========================================================================
	assign lz_dvd    = lzc(dvd_abs_q);
	assign lz_dvs    = lzc(dvs_abs_q);
	assign norm_dvd  = dvd_abs_q << lz_dvd[`DIV_LZC_WIDTH-1:0];
	assign norm_dvs  = dvs_abs_q << lz_dvs[`DIV_LZC_WIDTH-1:0];
	assign too_small = lz_dvd[`DIV_LZC_WIDTH-1:0] > lz_dvs[`DIV_LZC_WIDTH-1:0];
	// divisor zero, dividend zero or dividend below the divisor
	assign skip_c    = lz_dvs[`DIV_LZC_WIDTH] | lz_dvd[`DIV_LZC_WIDTH] | too_small;
	assign lz_diff   = lz_dvs[`DIV_LZC_WIDTH-1:0] - lz_dvd[`DIV_LZC_WIDTH-1:0];
	// iterations = ceil((lz_diff + 2) / 2)
	assign iter_sum  = {1'b0, lz_diff} + (`DIV_LZC_WIDTH + 1)'(3);

	// odd difference starts at x/8, even at x/4, both below 2d/3
	always_comb begin
		if (skip_c)
			rem_init_c = {1'b0, dvd_abs_q, 3'b000};
		else if (lz_diff[0])
			rem_init_c = {4'b0000, norm_dvd};
		else
			rem_init_c = {3'b000, norm_dvd, 1'b0};
	end

	// normalized operands are payload
	always_ff @(posedge clk) begin
		if (state_i == PRE) begin
			norm.norm_divisor <= norm_dvs;
			norm.rem_init     <= rem_init_c;
			// all ones quotient on divide by zero
			norm.quot_init    <= lz_dvs[`DIV_LZC_WIDTH] ? '1 : '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			norm.rem_shift <= '0;
			norm.quot_neg  <= 1'b0;
			norm.iter_cnt  <= '0;
			norm.skip      <= 1'b0;
			norm.div_zero  <= 1'b0;
		end else if (state_i == PRE) begin
			// early exit leaves the dividend unshifted
			norm.rem_shift <= skip_c ? '0 : lz_dvs[`DIV_LZC_WIDTH-1:0];
			norm.quot_neg  <= sign_xor_q & ~lz_dvs[`DIV_LZC_WIDTH];
			norm.iter_cnt  <= iter_sum[`DIV_LZC_WIDTH:1];
			norm.skip      <= skip_c;
			norm.div_zero  <= lz_dvs[`DIV_LZC_WIDTH];
		end
	end

endmodule

/* hdl/div_fsm.sv */
/*
 * divider controller
 * state sequencing, iteration count, start/finish handshakes and flush
 */
`timescale 1ns/1ns
`include "div_defs.svh"

module div_fsm import div_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       flush_i,
	input  logic       start_valid_i,
	output logic       start_ready_o,
	output logic       finish_valid_o,
	input  logic       finish_ready_i,
	output div_state_e state_o,
	div_norm_if.user   norm
);

	div_state_e state_q;
	div_state_e state_d;
	logic [`DIV_ITER_CNT_WIDTH-1:0] iter_left_q;

	// ========================================================================
	// next state
	// ========================================================================
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: if (start_valid_i) state_d = PRE;
			PRE:  state_d = LOAD;
			// early exit goes straight to the post stage
			LOAD: state_d = norm.skip ? POST : ITER;
			ITER: if (iter_left_q == `DIV_ITER_CNT_WIDTH'(1)) state_d = POST;
			POST: state_d = DONE;
			// hold the result until the consumer takes it
			DONE: if (finish_ready_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
		// flush beats everything
		if (flush_i)
			state_d = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// ========================================================================
	// iteration counter
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			iter_left_q <= '0;
		else if (state_q == LOAD)
			iter_left_q <= norm.iter_cnt;
		else if (state_q == ITER)
			iter_left_q <= iter_left_q - `DIV_ITER_CNT_WIDTH'(1);
	end

	assign start_ready_o  = (state_q == IDLE);
	assign finish_valid_o = (state_q == DONE);
	assign state_o        = state_q;

endmodule

/* hdl/div_rem_if.sv */
/*
 * redundant remainder and quotient pair
 * from the srt iteration to the post stage
 */
`timescale 1ns/1ns
`include "div_defs.svh"

interface div_rem_if;
	// carry-save partial remainder
	logic [`DIV_ITN_WIDTH-1:0] rem_sum;
	logic [`DIV_ITN_WIDTH-1:0] rem_carry;
	// on-the-fly quotient and quotient minus one
	logic [`DIV_WIDTH-1:0]     quot;
	logic [`DIV_WIDTH-1:0]     quot_m1;

	modport iter (output rem_sum, rem_carry, quot, quot_m1);
	modport post (input rem_sum, rem_carry, quot, quot_m1);
endinterface

/* hdl/div_norm_if.sv */
/*
 * normalized operands and setup values
 * from preprocessing to the controller, iteration and post stages
 */
`timescale 1ns/1ns
`include "div_defs.svh"

interface div_norm_if;
	logic [`DIV_WIDTH-1:0]          norm_divisor;
	logic [`DIV_ITN_WIDTH-1:0]      rem_init;
	logic [`DIV_WIDTH-1:0]          quot_init;
	logic [`DIV_LZC_WIDTH-1:0]      rem_shift;
	logic                           quot_neg;
	logic                           rem_neg;
	logic [`DIV_ITER_CNT_WIDTH-1:0] iter_cnt;
	logic                           skip;
	logic                           div_zero;

	modport prenorm (output norm_divisor, rem_init, quot_init, rem_shift, quot_neg, rem_neg,
		iter_cnt, skip, div_zero);
	modport user (input norm_divisor, rem_init, quot_init, rem_shift, quot_neg, rem_neg,
		iter_cnt, skip, div_zero);
endinterface

/* hdl/div_pkg.sv */
/*
 * shared types for the radix-4 srt divider
 * controller states, quotient digits, selection constants, lzc
 */
`include "div_defs.svh"

package div_pkg;

	// one-hot controller states
	typedef enum logic [5:0] {
		IDLE = 6'b00_0001,
		PRE  = 6'b00_0010,
		LOAD = 6'b00_0100,
		ITER = 6'b00_1000,
		POST = 6'b01_0000,
		DONE = 6'b10_0000
	} div_state_e;

	// one-hot radix-4 quotient digit
	typedef enum logic [4:0] {
		Q_NEG2 = 5'b0_0001,
		Q_NEG1 = 5'b0_0010,
		Q_ZERO = 5'b0_0100,
		Q_POS1 = 5'b0_1000,
		Q_POS2 = 5'b1_0000
	} quot_digit_e;

	// selection constants, signed, in units of 1/16 of 4w
	typedef struct packed {
		logic signed [`DIV_QDS_WIDTH-1:0] m_z;  // boundary -1 / 0
		logic signed [`DIV_QDS_WIDTH-1:0] m_p1; // boundary 0 / +1
		logic signed [`DIV_QDS_WIDTH-1:0] m_p2; // boundary +1 / +2
		logic signed [`DIV_QDS_WIDTH-1:0] m_n1; // boundary -2 / -1
	} qds_thresh_t;

	// returns {all_zero, leading zero count}
	function automatic logic [`DIV_LZC_WIDTH:0] lzc(input logic [`DIV_WIDTH-1:0] val);
		logic [`DIV_LZC_WIDTH-1:0] cnt;
		logic found;
		cnt   = '0;
		found = 1'b0;
		// scan down from the msb, first one wins
		for (int i = `DIV_WIDTH - 1; i >= 0; i--) begin
			if (!found && val[i]) begin
				found = 1'b1;
				cnt   = `DIV_LZC_WIDTH'(`DIV_WIDTH - 1 - i);
			end
		end
		return {~found, cnt};
	endfunction

endpackage

/* include/div_defs.svh */
/*
 * radix-4 srt divider sizing
 * operand, count and internal remainder widths
 */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand width
`define DIV_WIDTH 32
// leading-zero count bits
`define DIV_LZC_WIDTH 5
// sign + operand + three fraction bits
`define DIV_ITN_WIDTH 36
// iteration counter, up to 17 iterations when the divisor is one
`define DIV_ITER_CNT_WIDTH 5
// one digit-selection constant, in units of 1/16
`define DIV_QDS_WIDTH 6

`endif
